//--- include/tex_defines.svh
`ifndef TEX_DEFINES_SVH
`define TEX_DEFINES_SVH

// lanes per request, one memory bank per lane
`define TEX_NUM_LANES 4

// words per bank, addresses wrap at this depth
`define TEX_BANK_DEPTH 16

`define TEX_REQQ_DEPTH 2

`define TEX_INFO_BITS 8

`endif

//--- hw/tex_pkg.sv
`default_nettype none
`include "tex_defines.svh"

package tex_pkg;

    typedef logic [29:0] word_addr_t;
    typedef logic [31:0] byte_addr_t;
    typedef logic [31:0] texel_t;
    typedef logic [`TEX_NUM_LANES-1:0] lane_mask_t;
    typedef logic [1:0] texel_idx_t;

    typedef enum logic [1:0] {
        STRIDE_BYTE = 2'd0,
        STRIDE_HALF = 2'd1,
        STRIDE_WORD = 2'd2
    } tex_stride_e;

    typedef enum logic {
        FILTER_POINT    = 1'b0,
        FILTER_BILINEAR = 1'b1
    } tex_filter_e;

    // addr indexed as [lane][texel]
    typedef struct packed {
        lane_mask_t                              tmask;
        tex_filter_e                             filter;
        tex_stride_e                             stride;
        byte_addr_t [`TEX_NUM_LANES-1:0][3:0]    addr;
        logic [`TEX_INFO_BITS-1:0]               info;
    } tex_req_t;

    typedef struct packed {
        lane_mask_t                              tmask;
        texel_t [`TEX_NUM_LANES-1:0][3:0]        data;
        logic [`TEX_INFO_BITS-1:0]               info;
    } tex_rsp_t;

endpackage

`default_nettype wire

//--- hw/mem_pkg.sv
`default_nettype none
`include "tex_defines.svh"

package mem_pkg;

    // tag carries the texel index of the quad
    typedef struct packed {
        tex_pkg::word_addr_t addr;
        tex_pkg::texel_idx_t tag;
    } mem_lane_req_t;

    typedef struct packed {
        tex_pkg::texel_t     data;
        tex_pkg::texel_idx_t tag;
    } mem_lane_rsp_t;

    // one beat from the merger, lanes sharing a tag
    typedef struct packed {
        tex_pkg::lane_mask_t                     valid;
        tex_pkg::texel_t [`TEX_NUM_LANES-1:0]    data;
        tex_pkg::texel_idx_t                     tag;
    } mem_rsp_t;

endpackage

`default_nettype wire

//--- hw/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire              clk,
    input  wire              reset,
    input  wire              push,
    input  wire              pop,
    input  wire [WIDTH-1:0]  data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign do_pop   = pop && ~empty;
    // a full fifo still takes a push on the cycle it pops
    assign do_push  = push && (~full || do_pop);
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/tex_mem_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_defines.svh"

module tex_mem_bank (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         req_valid,
    input  wire mem_pkg::mem_lane_req_t req,
    output logic                        req_ready,
    output logic                        rsp_valid,
    output mem_pkg::mem_lane_rsp_t      rsp,
    input  wire                         rsp_ready
);

    localparam int AW = $clog2(`TEX_BANK_DEPTH);

    tex_pkg::texel_t        texels [`TEX_BANK_DEPTH];
    mem_pkg::mem_lane_rsp_t rd_word;
    logic                   fifo_empty;
    logic                   fifo_full;

    initial begin
        $readmemh("texels.hex", texels);
    end

    // word address wraps on the bank depth
    assign rd_word.data = texels[req.addr[AW-1:0]];
    assign rd_word.tag  = req.tag;

    assign req_ready = ~fifo_full;
    assign rsp_valid = ~fifo_empty;

    sync_fifo #(
        .WIDTH ($bits(mem_pkg::mem_lane_rsp_t)),
        .DEPTH (2)
    ) out_fifo (
        .clk      (clk),
        .reset    (reset),
        .push     (req_valid && req_ready),
        .pop      (rsp_valid && rsp_ready),
        .data_in  (rd_word),
        .data_out (rsp),
        .empty    (fifo_empty),
        .full     (fifo_full)
    );

endmodule

`default_nettype wire

//--- hw/tex_rsp_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_defines.svh"

module tex_rsp_merge (
    input  wire tex_pkg::lane_mask_t                    bank_valid,
    input  wire mem_pkg::mem_lane_rsp_t [`TEX_NUM_LANES-1:0] bank_rsp,
    output tex_pkg::lane_mask_t                         bank_ready,
    output logic                                        rsp_valid,
    output mem_pkg::mem_rsp_t                           rsp,
    input  wire                                         rsp_ready
);

    localparam int N = `TEX_NUM_LANES;

    tex_pkg::texel_idx_t sel_tag;
    tex_pkg::lane_mask_t match;

    always_comb begin
        sel_tag = '0;
        // walk down so the lowest valid bank wins
        for (int i = N - 1; i >= 0; i--) begin
            if (bank_valid[i]) begin
                sel_tag = bank_rsp[i].tag;
            end
        end
        for (int i = 0; i < N; i++) begin
            match[i]       = bank_valid[i] && (bank_rsp[i].tag == sel_tag);
            rsp.data[i]    = bank_rsp[i].data;
        end
        rsp.valid = match;
        rsp.tag   = sel_tag;
    end

    assign rsp_valid  = |bank_valid;
    assign bank_ready = match & {N{rsp_ready}};

endmodule

`default_nettype wire

//--- hw/tex_memory.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_defines.svh"

module tex_memory (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire                                         req_valid,
    input  wire tex_pkg::tex_req_t                      req,
    output logic                                        req_ready,
    output tex_pkg::lane_mask_t                         mem_req_valid,
    output mem_pkg::mem_lane_req_t [`TEX_NUM_LANES-1:0] mem_req,
    input  wire tex_pkg::lane_mask_t                    mem_req_ready,
    input  wire                                         mem_rsp_valid,
    input  wire mem_pkg::mem_rsp_t                      mem_rsp,
    output logic                                        mem_rsp_ready,
    output logic                                        rsp_valid,
    output tex_pkg::tex_rsp_t                           rsp,
    input  wire                                         rsp_ready
);

    localparam int N     = `TEX_NUM_LANES;
    localparam int CTR_W = $clog2(N * 4 + 1);

    // waddr and offs are indexed as [texel][lane]
    typedef struct packed {
        tex_pkg::lane_mask_t               tmask;
        tex_pkg::tex_filter_e              filter;
        tex_pkg::tex_stride_e              stride;
        logic [3:0]                        dup;
        tex_pkg::word_addr_t [3:0][N-1:0]  waddr;
        logic [3:0][N-1:0][1:0]            offs;
        logic [`TEX_INFO_BITS-1:0]         info;
    } reqq_entry_t;

    reqq_entry_t in_entry;
    reqq_entry_t q;
    logic        reqq_push;
    logic        reqq_pop;
    logic        reqq_empty;
    logic        reqq_full;

    always_comb begin
        in_entry.tmask  = req.tmask;
        in_entry.filter = req.filter;
        in_entry.stride = req.stride;
        in_entry.info   = req.info;
        for (int j = 0; j < 4; j++) begin
            in_entry.dup[j] = req.tmask[0];
            for (int i = 0; i < N; i++) begin
                in_entry.waddr[j][i] = req.addr[i][j][31:2];
                in_entry.offs[j][i]  = req.addr[i][j][1:0];
                // any active lane off lane 0's word breaks the shared fetch
                if (req.tmask[i] && (req.addr[i][j][31:2] != req.addr[0][j][31:2])) begin
                    in_entry.dup[j] = 1'b0;
                end
            end
        end
    end

    assign reqq_push = req_valid && req_ready;
    assign req_ready = ~reqq_full;

    sync_fifo #(
        .WIDTH ($bits(reqq_entry_t)),
        .DEPTH (`TEX_REQQ_DEPTH)
    ) reqq (
        .clk      (clk),
        .reset    (reset),
        .push     (reqq_push),
        .pop      (reqq_pop),
        .data_in  (in_entry),
        .data_out (q),
        .empty    (reqq_empty),
        .full     (reqq_full)
    );

    // texel issue
    tex_pkg::texel_idx_t req_idx;
    tex_pkg::lane_mask_t sent_mask;
    tex_pkg::lane_mask_t req_fire;
    tex_pkg::lane_mask_t dup_mask;
    logic                texels_done;
    logic                texel_valid;
    logic                req_dup;
    logic                is_last_texel;
    logic                sent_all_ready;
    logic                last_texel_sent;

    assign texel_valid   = ~reqq_empty && ~texels_done;
    assign req_dup       = q.dup[req_idx];
    assign is_last_texel = (q.filter == tex_pkg::FILTER_BILINEAR) ? (req_idx == 2'd3)
                                                                   : (req_idx == 2'd0);
    assign req_fire      = mem_req_valid & mem_req_ready;

    assign sent_all_ready  = (&(mem_req_ready | sent_mask | ~q.tmask))
                          || (req_dup && mem_req_ready[0]);
    assign last_texel_sent = texel_valid && sent_all_ready && is_last_texel;

    always_ff @(posedge clk) begin
        if (reset || last_texel_sent) begin
            req_idx <= '0;
        end else if (texel_valid && sent_all_ready) begin
            req_idx <= req_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || reqq_pop) begin
            texels_done <= 1'b0;
        end else if (last_texel_sent) begin
            texels_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || sent_all_ready) begin
            sent_mask <= '0;
        end else begin
            sent_mask <= sent_mask | req_fire;
        end
    end

    always_comb begin
        for (int i = 0; i < N; i++) begin
            dup_mask[i]    = (i == 0) || ~req_dup;
            mem_req[i].addr = q.waddr[req_idx][i];
            mem_req[i].tag  = req_idx;
        end
        mem_req_valid = {N{texel_valid}} & q.tmask & dup_mask & ~sent_mask;
    end

    // response gather
    tex_pkg::texel_t [3:0][N-1:0] rsp_texels;
    tex_pkg::texel_t [3:0][N-1:0] rsp_texels_n;
    tex_pkg::tex_rsp_t            rsp_n;
    tex_pkg::texel_idx_t          rsp_idx;
    tex_pkg::lane_mask_t          rsp_cur_tmask;
    logic [CTR_W-1:0]             rsp_rem_ctr;
    logic [CTR_W-1:0]             rsp_cur_cnt;
    logic [CTR_W-1:0]             req_cnt;
    logic                         rsp_dup;
    logic                         rsp_fire;
    logic                         rsp_texels_done;
    logic                         stall_out;

    assign rsp_idx       = mem_rsp.tag;
    assign rsp_dup       = q.dup[rsp_idx];
    assign rsp_cur_tmask = rsp_dup ? q.tmask : mem_rsp.valid;
    assign rsp_cur_cnt   = CTR_W'($countones(rsp_cur_tmask));
    assign req_cnt       = CTR_W'($countones(q.tmask));
    assign rsp_fire      = mem_rsp_valid && mem_rsp_ready;

    always_comb begin
        tex_pkg::texel_t src;
        tex_pkg::texel_t shifted;
        logic [1:0]      off;
        rsp_texels_n = rsp_texels;
        for (int i = 0; i < N; i++) begin
            src     = (rsp_dup ? mem_rsp.data[0] : mem_rsp.data[i]) & {32{rsp_cur_tmask[i]}};
            off     = q.offs[rsp_idx][i];
            shifted = src;
            if (off[1]) begin
                shifted[15:0] = src[31:16];
            end
            if (off[0]) begin
                shifted[7:0] = shifted[15:8];
            end
            case (q.stride)
                tex_pkg::STRIDE_BYTE: shifted = {24'b0, shifted[7:0]};
                tex_pkg::STRIDE_HALF: shifted = {16'b0, shifted[15:0]};
                default: shifted = shifted;
            endcase
            rsp_texels_n[rsp_idx][i] = rsp_texels[rsp_idx][i] | shifted;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || reqq_pop) begin
            rsp_texels <= '0;
        end else if (rsp_fire) begin
            rsp_texels <= rsp_texels_n;
        end
    end

    // loaded by the first lane request of the head entry
    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_rem_ctr <= '0;
        end else if ((|req_fire) && (rsp_rem_ctr == '0)) begin
            rsp_rem_ctr <= (q.filter == tex_pkg::FILTER_BILINEAR) ? (req_cnt << 2) : req_cnt;
        end else if (rsp_fire) begin
            rsp_rem_ctr <= rsp_rem_ctr - rsp_cur_cnt;
        end
    end

    assign stall_out       = rsp_valid && ~rsp_ready;
    assign rsp_texels_done = rsp_fire && (rsp_rem_ctr == rsp_cur_cnt);
    assign reqq_pop        = rsp_texels_done;
    // only the completing beat waits on the output register
    assign mem_rsp_ready   = ~stall_out || (rsp_rem_ctr != rsp_cur_cnt);

    always_comb begin
        rsp_n.tmask = q.tmask;
        rsp_n.info  = q.info;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < 4; j++) begin
                rsp_n.data[i][j] = rsp_texels_n[j][i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_valid <= 1'b0;
        end else if (~stall_out) begin
            rsp_valid <= rsp_texels_done;
        end
    end

    always_ff @(posedge clk) begin
        if (~stall_out) begin
            rsp <= rsp_n;
        end
    end

endmodule

`default_nettype wire

//--- hw/tex_mem_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_defines.svh"

module tex_mem_top (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    req_valid,
    input  wire tex_pkg::tex_req_t req,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output tex_pkg::tex_rsp_t      rsp,
    input  wire                    rsp_ready
);

    localparam int N = `TEX_NUM_LANES;

    tex_pkg::lane_mask_t              lane_req_valid;
    tex_pkg::lane_mask_t              lane_req_ready;
    mem_pkg::mem_lane_req_t [N-1:0]   lane_req;
    tex_pkg::lane_mask_t              lane_rsp_valid;
    tex_pkg::lane_mask_t              lane_rsp_ready;
    mem_pkg::mem_lane_rsp_t [N-1:0]   lane_rsp;
    logic                             merged_valid;
    logic                             merged_ready;
    mem_pkg::mem_rsp_t                merged_rsp;

    tex_memory tex_mem (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .mem_req_valid (lane_req_valid),
        .mem_req       (lane_req),
        .mem_req_ready (lane_req_ready),
        .mem_rsp_valid (merged_valid),
        .mem_rsp       (merged_rsp),
        .mem_rsp_ready (merged_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready)
    );

    for (genvar i = 0; i < N; i++) begin : g_bank
        tex_mem_bank bank (
            .clk       (clk),
            .reset     (reset),
            .req_valid (lane_req_valid[i]),
            .req       (lane_req[i]),
            .req_ready (lane_req_ready[i]),
            .rsp_valid (lane_rsp_valid[i]),
            .rsp       (lane_rsp[i]),
            .rsp_ready (lane_rsp_ready[i])
        );
    end

    tex_rsp_merge merge (
        .bank_valid (lane_rsp_valid),
        .bank_rsp   (lane_rsp),
        .bank_ready (lane_rsp_ready),
        .rsp_valid  (merged_valid),
        .rsp        (merged_rsp),
        .rsp_ready  (merged_ready)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- testbench/tex_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "tex_defines.svh"

module tex_mem_tb;

    localparam int N               = `TEX_NUM_LANES;
    localparam int NUM_TESTS       = 20;
    localparam int WATCHDOG_CYCLES = 200 * NUM_TESTS + 10;

    localparam tex_pkg::tex_filter_e POINT = tex_pkg::FILTER_POINT;
    localparam tex_pkg::tex_filter_e BILIN = tex_pkg::FILTER_BILINEAR;
    localparam tex_pkg::tex_stride_e BYTE  = tex_pkg::STRIDE_BYTE;
    localparam tex_pkg::tex_stride_e HALF  = tex_pkg::STRIDE_HALF;
    localparam tex_pkg::tex_stride_e WORD  = tex_pkg::STRIDE_WORD;

    logic              clk;
    logic              reset;
    logic              req_valid;
    tex_pkg::tex_req_t req;
    logic              req_ready;
    logic              rsp_valid;
    tex_pkg::tex_rsp_t rsp;
    logic              rsp_ready = 1'b1;

    tex_pkg::texel_t   ref_mem [`TEX_BANK_DEPTH];
    string             test_name [NUM_TESTS];
    tex_pkg::tex_req_t test_req [NUM_TESTS];
    bit                test_stall [NUM_TESTS];
    int                rcv_count = 0;
    int                seed = 27283;

    tb_clock #(.PERIOD(8.0)) clk_gen (.clk(clk));

    tex_mem_top dut0 (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    // addr = base + lane * lane_step + texel * texel_step
    function automatic tex_pkg::tex_req_t make_req(tex_pkg::lane_mask_t tmask,
            tex_pkg::tex_filter_e filter, tex_pkg::tex_stride_e stride,
            tex_pkg::byte_addr_t base, int lane_step, int texel_step);
        tex_pkg::tex_req_t r;
        r        = '0;
        r.tmask  = tmask;
        r.filter = filter;
        r.stride = stride;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < 4; j++) begin
                r.addr[i][j] = base + tex_pkg::byte_addr_t'(i * lane_step + j * texel_step);
            end
        end
        return r;
    endfunction

    task automatic set_test(int k, string name, bit stall, tex_pkg::tex_req_t r);
        test_name[k]     = name;
        test_stall[k]    = stall;
        test_req[k]      = r;
        test_req[k].info = `TEX_INFO_BITS'(8'h40 + k);
    endtask

    task automatic build_table();
        set_test(0, "point_word", 1'b0, make_req(4'hf, POINT, WORD, 32'h00, 4, 4));
        set_test(1, "point_word_wrap", 1'b0, make_req(4'hf, POINT, WORD, 32'h3c, 12, 4));
        set_test(2, "bilinear_word", 1'b0, make_req(4'hf, BILIN, WORD, 32'h04, 16, 4));
        set_test(3, "bilinear_word_far", 1'b0, make_req(4'hf, BILIN, WORD, 32'h100, 20, 36));
        set_test(4, "byte_offsets", 1'b0, make_req(4'hf, BILIN, BYTE, 32'h01, 1, 6));
        set_test(5, "byte_offsets_b", 1'b0, make_req(4'hf, BILIN, BYTE, 32'h27, 5, 3));
        set_test(6, "half_offsets", 1'b0, make_req(4'hf, BILIN, HALF, 32'h20, 2, 6));
        set_test(7, "half_point", 1'b0, make_req(4'hf, POINT, HALF, 32'h0e, 10, 2));
        set_test(8, "dup_word", 1'b0, make_req(4'hf, BILIN, WORD, 32'h14, 0, 4));
        set_test(9, "dup_byte_in_word", 1'b0, make_req(4'hf, BILIN, BYTE, 32'h08, 1, 4));
        set_test(10, "dup_mask_0101", 1'b0, make_req(4'h5, POINT, WORD, 32'h30, 0, 0));
        set_test(11, "dup_half_1101", 1'b0, make_req(4'hd, BILIN, HALF, 32'h1a, 0, 8));
        set_test(12, "mask_1010", 1'b0, make_req(4'ha, BILIN, HALF, 32'h22, 2, 8));
        set_test(13, "burst_word", 1'b1, make_req(4'hf, BILIN, WORD, 32'h08, 8, 4));
        set_test(14, "burst_mask", 1'b1, make_req(4'h6, BILIN, BYTE, 32'h33, 0, 1));
        set_test(15, "burst_point", 1'b1, make_req(4'hf, POINT, HALF, 32'h02, 16, 0));
        set_test(16, "burst_dup", 1'b1, make_req(4'hf, BILIN, HALF, 32'h2c, 0, 2));
        set_test(17, "burst_byte", 1'b1, make_req(4'hf, BILIN, BYTE, 32'h05, 7, 9));
        set_test(18, "burst_lane3", 1'b1, make_req(4'h8, BILIN, WORD, 32'h3c, 0, 4));
        set_test(19, "burst_mix", 1'b1, make_req(4'hb, POINT, BYTE, 32'h11, 3, 0));
    endtask

    // reference model of the quad result
    function automatic tex_pkg::tex_rsp_t expected_rsp(tex_pkg::tex_req_t r);
        tex_pkg::tex_rsp_t   e;
        tex_pkg::byte_addr_t a;
        tex_pkg::texel_t     w;
        e.tmask = r.tmask;
        e.info  = r.info;
        e.data  = '0;
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < 4; j++) begin
                // point filtering fetches texel 0 only
                if (r.tmask[i] && (r.filter == BILIN || j == 0)) begin
                    a = r.addr[i][j];
                    w = ref_mem[(a >> 2) % `TEX_BANK_DEPTH];
                    case (r.stride)
                        BYTE: e.data[i][j] = {24'b0, w[{a[1:0], 3'b000} +: 8]};
                        HALF: e.data[i][j] = {16'b0, (a[1] ? w[31:16] : w[15:0])};
                        default: e.data[i][j] = w;
                    endcase
                end
            end
        end
        return e;
    endfunction

    task automatic compare(string what, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", what, expected, actual);
            $display("sim failed");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    // info first, so an out of order response shows up as such
    task automatic check_response(int k);
        tex_pkg::tex_rsp_t e;
        e = expected_rsp(test_req[k]);
        compare($sformatf("%s info", test_name[k]), 32'(e.info), 32'(rsp.info));
        compare($sformatf("%s tmask", test_name[k]), 32'(e.tmask), 32'(rsp.tmask));
        for (int i = 0; i < N; i++) begin
            for (int j = 0; j < 4; j++) begin
                compare($sformatf("%s lane %0d texel %0d", test_name[k], i, j),
                        e.data[i][j], rsp.data[i][j]);
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        $readmemh("texels.hex", ref_mem);
        build_table();
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            req_valid <= 1'b1;
            req       <= test_req[t];
            do begin
                @(posedge clk);
            end while (!req_ready);
        end
        req_valid <= 1'b0;
        wait (rcv_count == NUM_TESTS);
        repeat (4) @(posedge clk);
        $display("sim passed");
        $finish;
    end

    always @(posedge clk) begin
        // random back-pressure while a burst entry is the next one due
        if (rcv_count < NUM_TESTS && test_stall[rcv_count]) begin
            rsp_ready <= ($random(seed) & 1) != 0;
        end else begin
            rsp_ready <= 1'b1;
        end
        if (!reset && rsp_valid && rsp_ready && rcv_count < NUM_TESTS) begin
            check_response(rcv_count);
            rcv_count <= rcv_count + 1;
        end
    end

    always @(posedge clk) begin
        if (!reset && rsp_valid && rsp_ready && rcv_count >= NUM_TESTS) begin
            $display("a response arrived after the last expected one");
            $display("sim failed");
            $fatal(1, "unexpected response");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: not all responses arrived within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
hw/tex_pkg.sv
hw/mem_pkg.sv
hw/sync_fifo.sv
hw/tex_mem_bank.sv
hw/tex_rsp_merge.sv
hw/tex_memory.sv
hw/tex_mem_top.sv
testbench/tb_clock.sv
testbench/tex_mem_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the texel fetch testbench with Verilator
# texels.hex is read relative to the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f compile.f --top-module tex_mem_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/Vtex_mem_tb
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
fi
exit "$status"

//--- texels.hex
// one 32-bit texel word per line, word addresses 0 to 15
// every byte differs so that shifts and zero extension show up
8c1f2a03
91e4b715
a2d3c826
b3c2d937
c4b1ea48
d5a0fb59
e69f0c6a
f78e1d7b
087d2e8c
196c3f9d
2a5b40ae
3b4a51bf
4c3962c0
5d2873d1
6e1784e2
7f0695f3
